// File: sim.f
common/simd_alu_pkg.sv
source/alu_decode.sv
source/alu_int_unit.sv
source/alu_compare.sv
source/alu_multiplier.sv
source/alu_issue_ctrl.sv
source/simd_alu.sv
sim/simd_alu_asserts.sv
sim/simd_alu_tb.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the SIMD ALU testbench with Verilator
LOG=sim.log

verilator --binary --timing --assert --top-module simd_alu_tb -f sim.f -o simd_alu_sim \
  > build.log 2>&1 \
  && ./obj_dir/simd_alu_sim > "$LOG" 2>&1 \
  || { echo "Build or simulation failed, see build.log and $LOG"; exit 1; }

grep -q -x "Done: no errors" "$LOG" \
  && echo "PASS" \
  || { echo "FAIL, see $LOG"; exit 1; }

// File: sim/simd_alu_tb.sv
`timescale 1ns/1ps

module simd_alu_tb import simd_alu_pkg::*;
();

  localparam int MUL_LATENCY = 3;
  localparam int MAX_CYCLES  = 2000; // Well above the length of all tests

  logic        clk;
  logic        rst;
  logic [31:0] control;
  data_t       src1;
  data_t       src2;
  data_t       src3;
  logic        vcc_in;
  logic        exec_in;
  logic        start;
  logic        done;
  logic        busy;
  logic        illegal;
  data_t       vgpr_data;
  logic        vgpr_we;
  logic        vcc_out;

  int error_count = 0;
  int check_count = 0;
  int cycle_count = 0;

  simd_alu #(
    .MUL_LATENCY (MUL_LATENCY)
  ) u_dut (
    .clk       (clk),
    .rst       (rst),
    .control   (control),
    .src1      (src1),
    .src2      (src2),
    .src3      (src3),
    .vcc_in    (vcc_in),
    .exec_in   (exec_in),
    .start     (start),
    .done      (done),
    .busy      (busy),
    .illegal   (illegal),
    .vgpr_data (vgpr_data),
    .vgpr_we   (vgpr_we),
    .vcc_out   (vcc_out)
  );

  initial
  begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  always @(posedge clk)
  begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= MAX_CYCLES)
    begin
      $display("Timeout: run stopped after %0d cycles", cycle_count);
      $display("Done: errors found");
      $finish;
    end
  end

  function automatic data_t rand_word();
    return $urandom;
  endfunction

  function automatic logic rand_bit();
    data_t r;
    r = $urandom;
    return r[0];
  endfunction

  function automatic logic [31:0] make_ctrl(input logic [7:0] fmt, input logic [11:0] opc);
    return {fmt, 12'h000, opc};
  endfunction

  // Expected outputs straight from the instruction rules
  function automatic void expect_result(input logic [31:0] ctrl, input data_t a,
                                        input data_t b, input data_t c, input logic vcc,
                                        input logic exec, output data_t data, output logic we,
                                        output logic vcc_o, output logic ill, output logic mul);
    logic [7:0]  fmt;
    logic [11:0] opc;
    logic [32:0] wide;
    logic [63:0] prod;
    logic        known;
    logic        is_cmp;
    logic        in_cmp;
    logic        sgn;
    logic        lt;
    logic        eq;
    int          width;
    int          offset;
    fmt    = ctrl[31:24];
    opc    = ctrl[11:0];
    data   = '0;
    we     = 1'b1;
    vcc_o  = vcc;
    ill    = 1'b0;
    mul    = 1'b0;
    known  = 1'b1;
    is_cmp = 1'b0;
    sgn    = (opc >= CMP_I_BASE) && (opc < CMP_I_BASE + 12'd8);
    in_cmp = sgn || ((opc >= CMP_U_BASE) && (opc < CMP_U_BASE + 12'd8));
    prod   = {32'h0, a} * {32'h0, b};
    width  = int'(c[4:0]);
    offset = int'(b[4:0]);
    case (fmt)
      FMT_VOP1:
      begin
        if (opc == OPC_MOV)
          data = a;
        else
          known = 1'b0;
      end
      FMT_VOP2:
      begin
        case (opc)
          OPC_ADD:     wide = {1'b0, a} + {1'b0, b};
          OPC_SUB:     wide = {1'b0, a} - {1'b0, b};
          OPC_ADDC:    wide = {1'b0, a} + {1'b0, b} + {32'h0, vcc};
          OPC_AND:     data = a & b;
          OPC_OR:      data = a | b;
          OPC_LSHL:    data = b << a[4:0];
          OPC_LSHR:    data = b >> a[4:0];
          OPC_MAX:     data = (a > b) ? a : b;
          OPC_MIN:     data = (a < b) ? a : b;
          OPC_CNDMASK: data = vcc ? b : a;
          default:     known = 1'b0;
        endcase
        if (opc == OPC_ADD || opc == OPC_SUB || opc == OPC_ADDC)
        begin
          data  = wide[31:0];
          vcc_o = wide[32]; // Carry or borrow
        end
      end
      FMT_VOPC:
      begin
        if (in_cmp)
          is_cmp = 1'b1;
        else
          known = 1'b0;
      end
      FMT_VOP3A:
      begin
        if (in_cmp)
          is_cmp = 1'b1;
        else
        begin
          case (opc)
            OPC_AND3:   data = a & b;
            OPC_BFI:
            begin
              for (int i = 0; i < 32; i++)
                data[i] = a[i] ? b[i] : c[i]; // Mask bit picks the source
            end
            OPC_MUL_LO:
            begin
              data = prod[31:0];
              mul  = 1'b1;
            end
            OPC_MUL_HI:
            begin
              data = prod[63:32];
              mul  = 1'b1;
            end
            OPC_BFE:
            begin
              for (int i = 0; i < 32; i++)
              begin
                if (i < width && offset + i < 32)
                  data[i] = a[offset+i]; // Bits past the top read as zero
              end
            end
            default:    known = 1'b0;
          endcase
        end
      end
      default:
        known = 1'b0;
    endcase
    if (is_cmp)
    begin
      if (sgn)
        lt = (a ^ 32'h8000_0000) < (b ^ 32'h8000_0000); // Offset binary keeps signed order
      else
        lt = (a < b);
      eq = (a == b);
      case (opc[2:0])
        3'd0:    vcc_o = 1'b0;
        3'd1:    vcc_o = lt;
        3'd2:    vcc_o = eq;
        3'd3:    vcc_o = lt | eq;
        3'd4:    vcc_o = !lt && !eq;
        3'd5:    vcc_o = !eq;
        3'd6:    vcc_o = !lt;
        default: vcc_o = 1'b1;
      endcase
      we = 1'b0;
    end
    if (!known)
    begin
      ill   = 1'b1;
      we    = 1'b0;
      vcc_o = vcc;
    end
    if (!exec)
    begin
      we    = 1'b0;
      vcc_o = vcc;
      mul   = 1'b0;
    end
  endfunction

  task automatic check_data(input string name, input data_t exp, input data_t act);
    check_count++;
    if (act !== exp)
    begin
      error_count++;
      $display("[FAIL] %s expected 0x%08h got 0x%08h", name, exp, act);
    end
  endtask

  task automatic check_bit(input string name, input logic exp, input logic act);
    check_count++;
    if (act !== exp)
    begin
      error_count++;
      $display("[FAIL] %s expected 0x%h got 0x%h", name, exp, act);
    end
  endtask

  // Issues one start at a falling edge and checks its completion
  task automatic run_op(input logic [31:0] ctrl, input data_t a, input data_t b,
                        input data_t c, input logic vcc, input logic exec);
    data_t exp_data;
    logic  exp_we;
    logic  exp_vcc;
    logic  exp_ill;
    logic  exp_mul;
    int    cycles;
    expect_result(ctrl, a, b, c, vcc, exec, exp_data, exp_we, exp_vcc, exp_ill, exp_mul);
    control = ctrl;
    src1    = a;
    src2    = b;
    src3    = c;
    vcc_in  = vcc;
    exec_in = exec;
    start   = 1'b1;
    @(posedge clk);
    @(negedge clk);
    start  = 1'b0;
    cycles = 1;
    if (exp_mul)
    begin
      while (!done && cycles < MUL_LATENCY + 4)
      begin
        check_bit("busy", 1'b1, busy);
        @(negedge clk);
        cycles++;
      end
    end
    if (!done)
    begin
      error_count++;
      $display("No done for control word 0x%08h within %0d cycles", ctrl, cycles);
    end
    else
    begin
      if (exp_mul && cycles != MUL_LATENCY)
      begin
        error_count++;
        $display("Multiply done after %0d cycles instead of %0d", cycles, MUL_LATENCY);
      end
      check_bit("vgpr_we", exp_we, vgpr_we);
      if (exp_we)
        check_data("vgpr_data", exp_data, vgpr_data);
      check_bit("vcc_out", exp_vcc, vcc_out);
      check_bit("illegal", exp_ill, illegal);
      check_bit("busy", exp_mul, busy);
    end
    if (exp_mul)
    begin
      @(negedge clk);
      check_bit("busy", 1'b0, busy); // Drops right after the multiply result
    end
  endtask

  task automatic test_reset();
    check_bit("done", 1'b0, done);
    check_bit("busy", 1'b0, busy);
    check_bit("illegal", 1'b0, illegal);
    check_bit("vgpr_we", 1'b0, vgpr_we);
    check_bit("vcc_out", 1'b0, vcc_out);
    check_data("vgpr_data", '0, vgpr_data);
  endtask

  task automatic test_vop_ops();
    logic [11:0] ops [10];
    ops = '{OPC_ADD, OPC_SUB, OPC_ADDC, OPC_AND, OPC_OR,
            OPC_LSHL, OPC_LSHR, OPC_MAX, OPC_MIN, OPC_CNDMASK};
    for (int rep = 0; rep < 6; rep++)
    begin
      run_op(make_ctrl(FMT_VOP1, OPC_MOV), rand_word(), rand_word(), rand_word(),
             rand_bit(), 1'b1);
      for (int i = 0; i < 10; i++)
        run_op(make_ctrl(FMT_VOP2, ops[i]), rand_word(), rand_word(), rand_word(),
               rand_bit(), 1'b1);
    end
    run_op(make_ctrl(FMT_VOP2, OPC_ADD), 32'hFFFF_FFFF, 32'h1, 32'h0, 1'b0, 1'b1);
    run_op(make_ctrl(FMT_VOP2, OPC_SUB), 32'h0, 32'h1, 32'h0, 1'b0, 1'b1);
    run_op(make_ctrl(FMT_VOP2, OPC_SUB), 32'h5, 32'h5, 32'h0, 1'b1, 1'b1);
    run_op(make_ctrl(FMT_VOP2, OPC_ADDC), 32'hFFFF_FFFF, 32'h0, 32'h0, 1'b1, 1'b1);
  endtask

  task automatic test_compares();
    logic [7:0]  fmts  [2];
    logic [11:0] bases [2];
    data_t       pa    [4];
    data_t       pb    [4];
    data_t       same;
    fmts  = '{FMT_VOPC, FMT_VOP3A};
    bases = '{CMP_I_BASE, CMP_U_BASE};
    same  = rand_word();
    pa[0] = 32'h7FFF_FFFF;
    pb[0] = 32'h8000_0000;
    pa[1] = 32'h8000_0000 | rand_word();
    pb[1] = 32'h7FFF_FFFF & rand_word();
    pa[2] = 32'h7FFF_FFFF & rand_word();
    pb[2] = 32'h8000_0000 | rand_word();
    pa[3] = same;
    pb[3] = same;
    for (int f = 0; f < 2; f++)
      for (int s = 0; s < 2; s++)
        for (int cond = 0; cond < 8; cond++)
          for (int p = 0; p < 4; p++)
            run_op(make_ctrl(fmts[f], bases[s] + 12'(cond)), pa[p], pb[p], rand_word(),
                   rand_bit(), 1'b1);
  endtask

  task automatic test_bitfield();
    for (int rep = 0; rep < 3; rep++)
    begin
      run_op(make_ctrl(FMT_VOP3A, OPC_AND3), rand_word(), rand_word(), rand_word(),
             rand_bit(), 1'b1);
      run_op(make_ctrl(FMT_VOP3A, OPC_BFE), rand_word(), rand_word(), rand_word(),
             rand_bit(), 1'b1);
      run_op(make_ctrl(FMT_VOP3A, OPC_BFI), rand_word(), rand_word(), rand_word(),
             rand_bit(), 1'b1);
    end
    run_op(make_ctrl(FMT_VOP3A, OPC_BFE), rand_word(), 32'h4, 32'hFFFF_FFE0, 1'b0, 1'b1);
    run_op(make_ctrl(FMT_VOP3A, OPC_BFE), 32'hF123_4567, 32'h1C, 32'h8, 1'b1, 1'b1);
    run_op(make_ctrl(FMT_VOP3A, OPC_BFE), 32'hFFFF_FFFF, 32'h0, 32'h1F, 1'b0, 1'b1);
    run_op(make_ctrl(FMT_VOP3A, OPC_BFI), 32'hFFFF_0000, rand_word(), rand_word(), 1'b0, 1'b1);
  endtask

  task automatic test_multiplies();
    for (int rep = 0; rep < 4; rep++)
    begin
      run_op(make_ctrl(FMT_VOP3A, OPC_MUL_LO), rand_word(), rand_word(), rand_word(),
             rand_bit(), 1'b1);
      run_op(make_ctrl(FMT_VOP3A, OPC_MUL_HI), rand_word(), rand_word(), rand_word(),
             rand_bit(), 1'b1);
    end
    run_op(make_ctrl(FMT_VOP3A, OPC_MUL_LO), 32'hFFFF_FFFF, 32'hFFFF_FFFF, 32'h0, 1'b1, 1'b1);
    run_op(make_ctrl(FMT_VOP3A, OPC_MUL_HI), 32'hFFFF_FFFF, 32'hFFFF_FFFF, 32'h0, 1'b0, 1'b1);
    run_op(make_ctrl(FMT_VOP3A, OPC_MUL_HI), 32'h0, rand_word(), 32'h0, 1'b1, 1'b1);
    run_op(make_ctrl(FMT_VOP3A, OPC_MUL_HI), 32'h8000_0000, 32'h2, 32'h0, 1'b0, 1'b1);
    run_op(make_ctrl(FMT_VOP2, OPC_MOV), rand_word(), 32'h0, 32'h0, 1'b0, 1'b1);
  endtask

  task automatic test_exec_illegal();
    for (int v = 0; v < 2; v++)
    begin
      run_op(make_ctrl(FMT_VOP1, OPC_MOV), rand_word(), rand_word(), 32'h0, v[0], 1'b0);
      run_op(make_ctrl(FMT_VOP2, OPC_ADD), 32'hFFFF_FFFF, 32'h1, 32'h0, v[0], 1'b0);
      run_op(make_ctrl(FMT_VOPC, CMP_U_BASE + 12'd7), rand_word(), rand_word(), 32'h0,
             v[0], 1'b0);
      run_op(make_ctrl(FMT_VOP3A, OPC_MUL_LO), rand_word(), rand_word(), 32'h0, v[0], 1'b0);
      run_op(make_ctrl(FMT_VOP3A, OPC_BFE), rand_word(), rand_word(), rand_word(), v[0], 1'b0);
    end
    run_op(make_ctrl(8'h55, OPC_ADD), rand_word(), rand_word(), 32'h0, 1'b1, 1'b1);
    run_op(make_ctrl(FMT_VOP1, 12'h002), rand_word(), rand_word(), 32'h0, 1'b0, 1'b1);
    run_op(make_ctrl(FMT_VOP2, 12'h100), rand_word(), rand_word(), 32'h0, 1'b1, 1'b1);
    run_op(make_ctrl(FMT_VOPC, 12'h010), rand_word(), rand_word(), 32'h0, 1'b0, 1'b1);
    run_op(make_ctrl(FMT_VOPC, 12'h0C8), rand_word(), rand_word(), 32'h0, 1'b1, 1'b1);
    run_op(make_ctrl(FMT_VOP3A, 12'h000), rand_word(), rand_word(), 32'h0, 1'b0, 1'b1);
    run_op(make_ctrl(FMT_VOP3A, OPC_ADD), rand_word(), rand_word(), 32'h0, 1'b1, 1'b0);
  endtask

  initial
  begin
    rst     = 1'b1;
    control = '0;
    src1    = '0;
    src2    = '0;
    src3    = '0;
    vcc_in  = 1'b0;
    exec_in = 1'b0;
    start   = 1'b0;
    void'($urandom(32'hd605));
    repeat (4) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;
    test_reset();
    test_vop_ops();
    test_compares();
    test_bitfield();
    test_multiplies();
    test_exec_illegal();
    $display("Checks run: %0d, errors: %0d", check_count, error_count);
    if (error_count == 0)
      $display("Done: no errors");
    else
      $display("Done: errors found");
    $finish;
  end

endmodule

// File: sim/simd_alu_asserts.sv
`timescale 1ns/1ps

module simd_alu_asserts
#(
  parameter int MUL_LATENCY = 3
)
(
  input logic clk,
  input logic rst,
  input logic start,
  input logic mul_start,
  input logic done,
  input logic busy
);

  // Issuer holds off while a multiply is in flight
  no_start_while_busy: assert property (
    @(posedge clk) disable iff (rst) !(start && busy)
  ) else $error("start raised while busy");

  // Back-to-back done only from back-to-back starts
  done_single_cycle: assert property (
    @(posedge clk) disable iff (rst) (done && $past(done)) |-> ($past(start) && $past(start, 2))
  ) else $error("done high for two cycles without two starts");

  mul_done_latency: assert property (
    @(posedge clk) disable iff (rst) mul_start |-> ##MUL_LATENCY done
  ) else $error("multiply done not at the expected latency");

  busy_drops_after_done: assert property (
    @(posedge clk) disable iff (rst) (done && busy) |=> !busy
  ) else $error("busy still high after multiply done");

endmodule

bind simd_alu simd_alu_asserts #(
  .MUL_LATENCY (MUL_LATENCY)
) u_asserts (
  .clk       (clk),
  .rst       (rst),
  .start     (start),
  .mul_start (mul_start),
  .done      (done),
  .busy      (busy)
);

// File: source/simd_alu.sv
`timescale 1ns/1ps

module simd_alu import simd_alu_pkg::*;
#(
  parameter int MUL_LATENCY = 3
)
(
  input  logic        clk,
  input  logic        rst,
  input  logic [31:0] control,
  input  data_t       src1,
  input  data_t       src2,
  input  data_t       src3,
  input  logic        vcc_in,
  input  logic        exec_in,
  input  logic        start,
  output logic        done,
  output logic        busy,
  output logic        illegal,
  output data_t       vgpr_data,
  output logic        vgpr_we,
  output logic        vcc_out
);

  alu_op_e   op;
  cmp_cond_e cmp_cond;
  logic      cmp_signed;
  logic      legal;
  data_t     int_result;
  logic      int_carry;
  logic      cmp_flag;
  logic      mul_start;
  logic      mul_hi;
  data_t     mul_result;
  logic      mul_valid;

  alu_decode u_decode (
    .control    (control),
    .op         (op),
    .cmp_cond   (cmp_cond),
    .cmp_signed (cmp_signed),
    .legal      (legal)
  );

  alu_int_unit u_int (
    .op     (op),
    .src1   (src1),
    .src2   (src2),
    .src3   (src3),
    .vcc_in (vcc_in),
    .result (int_result),
    .carry  (int_carry)
  );

  alu_compare u_cmp (
    .src1       (src1),
    .src2       (src2),
    .cmp_cond   (cmp_cond),
    .cmp_signed (cmp_signed),
    .flag       (cmp_flag)
  );

  alu_multiplier #(
    .MUL_LATENCY (MUL_LATENCY)
  ) u_mul (
    .clk        (clk),
    .rst        (rst),
    .mul_start  (mul_start),
    .mul_hi     (mul_hi),
    .mul_a      (src1),
    .mul_b      (src2),
    .mul_result (mul_result),
    .mul_valid  (mul_valid)
  );

  alu_issue_ctrl #(
    .MUL_LATENCY (MUL_LATENCY)
  ) u_issue (
    .clk        (clk),
    .rst        (rst),
    .start      (start),
    .exec_in    (exec_in),
    .vcc_in     (vcc_in),
    .op         (op),
    .legal      (legal),
    .int_result (int_result),
    .int_carry  (int_carry),
    .cmp_flag   (cmp_flag),
    .mul_result (mul_result),
    .mul_valid  (mul_valid),
    .mul_start  (mul_start),
    .mul_hi     (mul_hi),
    .done       (done),
    .busy       (busy),
    .illegal    (illegal),
    .vgpr_data  (vgpr_data),
    .vgpr_we    (vgpr_we),
    .vcc_out    (vcc_out)
  );

endmodule

// File: source/alu_issue_ctrl.sv
`timescale 1ns/1ps

module alu_issue_ctrl import simd_alu_pkg::*;
#(
  parameter int MUL_LATENCY = 3
)
(
  input  logic    clk,
  input  logic    rst,
  input  logic    start,
  input  logic    exec_in,
  input  logic    vcc_in,
  input  alu_op_e op,
  input  logic    legal,
  input  data_t   int_result,
  input  logic    int_carry,
  input  logic    cmp_flag,
  input  data_t   mul_result,
  input  logic    mul_valid,
  output logic    mul_start,
  output logic    mul_hi,
  output logic    done,
  output logic    busy,
  output logic    illegal,
  output data_t   vgpr_data,
  output logic    vgpr_we,
  output logic    vcc_out
);

  localparam int CNT_W = $clog2(MUL_LATENCY + 1);

  logic [CNT_W-1:0] mul_cnt;
  logic             accept;
  logic             is_mul;
  logic             launch;
  logic             vcc_next;
  logic             done_q;
  logic             we_q;
  logic             illegal_q;
  logic             vcc_q;
  logic             mul_vcc_q;
  data_t            data_q;

  assign busy      = (mul_cnt != '0);
  assign accept    = start & ~busy; // Starts while busy are dropped
  assign is_mul    = (op == OP_MUL_LO) || (op == OP_MUL_HI);
  assign launch    = accept & legal & exec_in & is_mul;
  assign mul_start = launch;
  assign mul_hi    = (op == OP_MUL_HI);

  // VCC source by op class
  always_comb
  begin
    if (!exec_in || !legal)
      vcc_next = vcc_in;
    else
    begin
      case (op)
        OP_CMP:                  vcc_next = cmp_flag;
        OP_ADD, OP_SUB, OP_ADDC: vcc_next = int_carry;
        default:                 vcc_next = vcc_in;
      endcase
    end
  end

  // Counts down the multiply in flight
  always_ff @(posedge clk or posedge rst)
  begin
    if (rst)
      mul_cnt <= '0;
    else if (launch)
      mul_cnt <= CNT_W'(MUL_LATENCY);
    else if (busy)
      mul_cnt <= mul_cnt - CNT_W'(1);
  end

  // Single-cycle results
  always_ff @(posedge clk or posedge rst)
  begin
    if (rst)
    begin
      done_q    <= 1'b0;
      we_q      <= 1'b0;
      illegal_q <= 1'b0;
      vcc_q     <= 1'b0;
      data_q    <= '0;
    end
    else
    begin
      done_q    <= accept & ~launch;
      we_q      <= accept & ~launch & legal & exec_in & (op != OP_CMP);
      illegal_q <= accept & ~legal;
      if (accept && !launch)
      begin
        data_q <= int_result;
        vcc_q  <= vcc_next;
      end
    end
  end

  always_ff @(posedge clk)
  begin
    if (launch)
      mul_vcc_q <= vcc_in; // VCC passes through a multiply
  end

  // Multiply completes straight from the pipeline
  assign done      = done_q | mul_valid;
  assign vgpr_we   = we_q | mul_valid;
  assign vgpr_data = mul_valid ? mul_result : data_q;
  assign vcc_out   = mul_valid ? mul_vcc_q : vcc_q;
  assign illegal   = illegal_q;

endmodule

// File: source/alu_multiplier.sv
`timescale 1ns/1ps

module alu_multiplier import simd_alu_pkg::*;
#(
  parameter int MUL_LATENCY = 3
)
(
  input  logic  clk,
  input  logic  rst,
  input  logic  mul_start,
  input  logic  mul_hi,
  input  data_t mul_a,
  input  data_t mul_b,
  output data_t mul_result,
  output logic  mul_valid
);

  localparam int LAST = MUL_LATENCY - 1;

  data_t                a_q;
  data_t                b_q;
  logic                 hi_q;
  logic                 vld_q;
  logic [2*DATA_W-1:0]  product;
  logic [2*DATA_W-1:0]  prod_pipe [1:LAST];
  logic                 hi_pipe   [1:LAST];
  logic                 vld_pipe  [1:LAST];

  // First stage holds the operands
  always_ff @(posedge clk or posedge rst)
  begin
    if (rst)
      vld_q <= 1'b0;
    else
      vld_q <= mul_start;
  end

  always_ff @(posedge clk)
  begin
    a_q  <= mul_a;
    b_q  <= mul_b;
    hi_q <= mul_hi;
  end

  assign product = (2*DATA_W)'(a_q) * (2*DATA_W)'(b_q); // Full unsigned product

  // Remaining stages carry the product
  always_ff @(posedge clk or posedge rst)
  begin
    if (rst)
    begin
      for (int i = 1; i <= LAST; i++)
        vld_pipe[i] <= 1'b0;
    end
    else
    begin
      vld_pipe[1] <= vld_q;
      for (int i = 2; i <= LAST; i++)
        vld_pipe[i] <= vld_pipe[i-1];
    end
  end

  always_ff @(posedge clk)
  begin
    prod_pipe[1] <= product;
    hi_pipe[1]   <= hi_q;
    for (int i = 2; i <= LAST; i++)
    begin
      prod_pipe[i] <= prod_pipe[i-1];
      hi_pipe[i]   <= hi_pipe[i-1];
    end
  end

  assign mul_result = hi_pipe[LAST] ? prod_pipe[LAST][2*DATA_W-1:DATA_W]
                                    : prod_pipe[LAST][DATA_W-1:0];
  assign mul_valid  = vld_pipe[LAST];

endmodule

// File: source/alu_compare.sv
`timescale 1ns/1ps

module alu_compare import simd_alu_pkg::*;
(
  input  data_t     src1,
  input  data_t     src2,
  input  cmp_cond_e cmp_cond,
  input  logic      cmp_signed,
  output logic      flag
);

  logic lt_s;
  logic lt_u;
  logic lt;
  logic eq;

  assign lt_s = ($signed(src1) < $signed(src2));
  assign lt_u = (src1 < src2);
  assign lt   = cmp_signed ? lt_s : lt_u;
  assign eq   = (src1 == src2); // Same for both forms

  always_comb
  begin
    case (cmp_cond)
      CMP_F:   flag = 1'b0;
      CMP_LT:  flag = lt;
      CMP_EQ:  flag = eq;
      CMP_LE:  flag = lt | eq;
      CMP_GT:  flag = ~(lt | eq);
      CMP_LG:  flag = ~eq;
      CMP_GE:  flag = ~lt;
      CMP_TRU: flag = 1'b1;
      default: flag = 1'b0;
    endcase
  end

endmodule

// File: source/alu_int_unit.sv
`timescale 1ns/1ps

module alu_int_unit import simd_alu_pkg::*;
(
  input  alu_op_e op,
  input  data_t   src1,
  input  data_t   src2,
  input  data_t   src3,
  input  logic    vcc_in,
  output data_t   result,
  output logic    carry
);

  logic [DATA_W:0] add_w;
  logic [DATA_W:0] sub_w;
  logic [DATA_W:0] addc_w;
  data_t           bfe_mask;
  data_t           bfe_val;

  // 33-bit forms so the top bit is carry or borrow
  assign add_w  = {1'b0, src1} + {1'b0, src2};
  assign sub_w  = {1'b0, src1} - {1'b0, src2};
  assign addc_w = {1'b0, src1} + {1'b0, src2} + {{DATA_W{1'b0}}, vcc_in};

  // Zero width gives an empty mask
  assign bfe_mask = (data_t'(1) << src3[4:0]) - data_t'(1);
  assign bfe_val  = (src1 >> src2[4:0]) & bfe_mask;

  always_comb
  begin
    result = '0;
    carry  = 1'b0;
    case (op)
      OP_MOV:
        result = src1;
      OP_ADD:
      begin
        result = add_w[DATA_W-1:0];
        carry  = add_w[DATA_W];
      end
      OP_SUB:
      begin
        result = sub_w[DATA_W-1:0];
        carry  = sub_w[DATA_W]; // Borrow
      end
      OP_ADDC:
      begin
        result = addc_w[DATA_W-1:0];
        carry  = addc_w[DATA_W];
      end
      OP_AND:
        result = src1 & src2;
      OP_OR:
        result = src1 | src2;
      OP_LSHL:
        result = src2 << src1[4:0]; // Reversed operands
      OP_LSHR:
        result = src2 >> src1[4:0];
      OP_MAX:
        result = (src1 >= src2) ? src1 : src2;
      OP_MIN:
        result = (src1 <= src2) ? src1 : src2;
      OP_CNDMASK:
        result = vcc_in ? src2 : src1;
      OP_BFE:
        result = bfe_val;
      OP_BFI:
        result = (src1 & src2) | (~src1 & src3);
      default:
        result = '0; // Compares and multiplies come from other units
    endcase
  end

endmodule

// File: source/alu_decode.sv
`timescale 1ns/1ps

module alu_decode import simd_alu_pkg::*;
(
  input  logic [31:0] control,
  output alu_op_e     op,
  output cmp_cond_e   cmp_cond,
  output logic        cmp_signed,
  output logic        legal
);

  logic [7:0]       fmt;
  logic [OPC_W-1:0] opc;
  logic             cmp_i;
  logic             cmp_u;

  assign fmt = control[FMT_MSB:FMT_LSB];
  assign opc = control[OPC_W-1:0];

  // Compare ranges cover eight opcodes each
  assign cmp_i = (opc[OPC_W-1:3] == CMP_I_BASE[OPC_W-1:3]);
  assign cmp_u = (opc[OPC_W-1:3] == CMP_U_BASE[OPC_W-1:3]);

  always_comb
  begin
    op         = OP_NONE;
    cmp_signed = 1'b0;
    case (fmt)
      FMT_VOP1:
      begin
        if (opc == OPC_MOV)
          op = OP_MOV;
      end
      FMT_VOP2:
      begin
        case (opc)
          OPC_ADD:     op = OP_ADD;
          OPC_SUB:     op = OP_SUB;
          OPC_ADDC:    op = OP_ADDC;
          OPC_AND:     op = OP_AND;
          OPC_OR:      op = OP_OR;
          OPC_LSHL:    op = OP_LSHL;
          OPC_LSHR:    op = OP_LSHR;
          OPC_MAX:     op = OP_MAX;
          OPC_MIN:     op = OP_MIN;
          OPC_CNDMASK: op = OP_CNDMASK;
          default:     op = OP_NONE;
        endcase
      end
      FMT_VOPC:
      begin
        if (cmp_i || cmp_u)
        begin
          op         = OP_CMP;
          cmp_signed = cmp_i;
        end
      end
      FMT_VOP3A:
      begin
        if (cmp_i || cmp_u)
        begin
          op         = OP_CMP; // Same compare block as VOPC
          cmp_signed = cmp_i;
        end
        else
        begin
          case (opc)
            OPC_AND3:   op = OP_AND;
            OPC_BFE:    op = OP_BFE;
            OPC_BFI:    op = OP_BFI;
            OPC_MUL_LO: op = OP_MUL_LO;
            OPC_MUL_HI: op = OP_MUL_HI;
            default:    op = OP_NONE;
          endcase
        end
      end
      default:
      begin
        op = OP_NONE; // Unknown format
      end
    endcase
  end

  assign cmp_cond = cmp_cond_e'(opc[2:0]);
  assign legal    = (op != OP_NONE);

endmodule

// File: common/simd_alu_pkg.sv
package simd_alu_pkg;

  // Data path
  localparam int DATA_W = 32;
  typedef logic [DATA_W-1:0] data_t;

  // Control word fields
  localparam int FMT_MSB = 31;
  localparam int FMT_LSB = 24;
  localparam int OPC_W   = 12;

  // Instruction formats, bits 31..24 of the control word
  typedef enum logic [7:0] {
    FMT_VOP2  = 8'h00,
    FMT_VOPC  = 8'h7C,
    FMT_VOP1  = 8'h7E,
    FMT_VOP3A = 8'hD2
  } alu_fmt_e;

  // Opcodes inside their format
  localparam logic [OPC_W-1:0] OPC_MOV     = 12'h001; // VOP1
  localparam logic [OPC_W-1:0] OPC_ADD     = 12'h025; // VOP2 from here
  localparam logic [OPC_W-1:0] OPC_SUB     = 12'h026;
  localparam logic [OPC_W-1:0] OPC_ADDC    = 12'h028;
  localparam logic [OPC_W-1:0] OPC_AND     = 12'h01B;
  localparam logic [OPC_W-1:0] OPC_OR      = 12'h01C;
  localparam logic [OPC_W-1:0] OPC_LSHL    = 12'h01A;
  localparam logic [OPC_W-1:0] OPC_LSHR    = 12'h016;
  localparam logic [OPC_W-1:0] OPC_MAX     = 12'h014;
  localparam logic [OPC_W-1:0] OPC_MIN     = 12'h013;
  localparam logic [OPC_W-1:0] OPC_CNDMASK = 12'h000;
  localparam logic [OPC_W-1:0] OPC_AND3    = 12'h11B; // VOP3A from here
  localparam logic [OPC_W-1:0] OPC_BFE     = 12'h148;
  localparam logic [OPC_W-1:0] OPC_BFI     = 12'h14A;
  localparam logic [OPC_W-1:0] OPC_MUL_LO  = 12'h169;
  localparam logic [OPC_W-1:0] OPC_MUL_HI  = 12'h16A;

  // Compare blocks of eight, low three bits give the condition
  localparam logic [OPC_W-1:0] CMP_I_BASE = 12'h080;
  localparam logic [OPC_W-1:0] CMP_U_BASE = 12'h0C0;

  // Decoded operation
  typedef enum logic [4:0] {
    OP_MOV,
    OP_ADD,
    OP_SUB,
    OP_ADDC,
    OP_AND,
    OP_OR,
    OP_LSHL,
    OP_LSHR,
    OP_MAX,
    OP_MIN,
    OP_CNDMASK,
    OP_CMP,
    OP_BFE,
    OP_BFI,
    OP_MUL_LO,
    OP_MUL_HI,
    OP_NONE
  } alu_op_e;

  // Compare conditions in opcode order
  typedef enum logic [2:0] {
    CMP_F,
    CMP_LT,
    CMP_EQ,
    CMP_LE,
    CMP_GT,
    CMP_LG,
    CMP_GE,
    CMP_TRU
  } cmp_cond_e;

endpackage
